// File: mips_datapath.f
+incdir+include
rtl/mips_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/result_stage.sv
rtl/mips_datapath.sv
tests/tb_mips_datapath.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# the simulator exit status carries pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mips_datapath \
    -Mdir obj_dir \
    -f mips_datapath.f

./obj_dir/Vtb_mips_datapath

// File: tests/tb_mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_consts.svh"

module tb_mips_datapath;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    // directed instructions plus their idle slots
    localparam int NUM_DIRECTED = 48;
    localparam int NUM_RANDOM   = 300;
    // random stream adds at most one idle cycle per instruction
    localparam int RUN_CYCLES   = RESET_CYCLES + NUM_DIRECTED + 2 * NUM_RANDOM + 10;

    logic                   clk;
    logic                   arst_n;
    logic                   inst_valid;
    mips_pkg::word_t        inst;
    logic                   result_valid;
    mips_pkg::word_t        result;
    mips_pkg::reg_addr_t    result_reg;
    logic                   illegal;
    logic [`MIPS_CNT_W-1:0] retired_count;

    // sequential model state
    mips_pkg::word_t        model_regs [`MIPS_NREGS];
    logic [`MIPS_CNT_W-1:0] model_count;
    logic [31:0]            lcg_state;

    // expected outputs, oldest first
    string                  exp_name [$];
    logic                   exp_bad [$];
    mips_pkg::reg_addr_t    exp_reg [$];
    mips_pkg::word_t        exp_data [$];
    logic [`MIPS_CNT_W-1:0] exp_count [$];

    // entry under comparison
    string                  cur_name;
    logic                   cur_bad;
    mips_pkg::reg_addr_t    cur_reg;
    mips_pkg::word_t        cur_data;
    logic [`MIPS_CNT_W-1:0] cur_count;

    mips_datapath u_mips_datapath
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .result_valid  (result_valid),
        .result        (result),
        .result_reg    (result_reg),
        .illegal       (illegal),
        .retired_count (retired_count)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // r-type word, fields in rd, rs, rt order
    function automatic mips_pkg::word_t enc_r(input logic [4:0] rd, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [5:0] funct);
        return {6'd0, rs, rt, rd, 5'd0, funct};
    endfunction

    // i-type word, fields in rt, rs, imm order
    function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input logic [4:0] rt,
                                              input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // one instruction on the model, returns its result
    function automatic mips_pkg::word_t exec_ref(input mips_pkg::word_t iw, output logic bad,
                                                 output mips_pkg::reg_addr_t dst);
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t sx;
        mips_pkg::word_t zx;
        mips_pkg::word_t res;
        a   = model_regs[iw[25:21]];
        b   = model_regs[iw[20:16]];
        sx  = {{16{iw[15]}}, iw[15:0]};
        zx  = {16'd0, iw[15:0]};
        bad = 1'b0;
        res = '0;
        // i-type writes rt
        dst = iw[20:16];
        case (iw[31:26])
            6'd0:
            begin
                dst = iw[15:11];
                case (iw[5:0])
                    6'd32:   res = a + b;
                    6'd34:   res = a - b;
                    6'd36:   res = a & b;
                    6'd37:   res = a | b;
                    6'd42:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: bad = 1'b1;
                endcase
            end
            6'd8:    res = a + sx;
            6'd12:   res = a & zx;
            6'd13:   res = a | zx;
            default: bad = 1'b1;
        endcase
        // r0 keeps its zero
        if (!bad && (dst != 5'd0))
        begin
            model_regs[dst] = res;
        end
        return res;
    endfunction

    task automatic check_word(input string name, input mips_pkg::word_t exp,
                              input mips_pkg::word_t act);
        if (exp !== act)
        begin
            $display("[FAIL] %s: result expected %h, actual %h", name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input string name, input mips_pkg::reg_addr_t exp,
                             input mips_pkg::reg_addr_t act);
        if (exp !== act)
        begin
            $display("[FAIL] %s: result_reg expected %0d, actual %0d", name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input logic [`MIPS_CNT_W-1:0] exp,
                               input logic [`MIPS_CNT_W-1:0] act);
        if (exp !== act)
        begin
            $display("[FAIL] %s: retired_count expected %0d, actual %0d", name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // drive one instruction and queue what the model expects
    task automatic issue(input string name, input mips_pkg::word_t iw);
        logic                bad;
        mips_pkg::reg_addr_t dst;
        mips_pkg::word_t     res;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = iw;
        res        = exec_ref(iw, bad, dst);
        if (!bad)
        begin
            model_count = model_count + `MIPS_CNT_W'(1);
        end
        exp_name.push_back(name);
        exp_bad.push_back(bad);
        exp_reg.push_back(dst);
        exp_data.push_back(res);
        exp_count.push_back(model_count);
    endtask

    // junk on inst while invalid, must be ignored
    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            inst_valid = 1'b0;
            inst       = lcg_next();
        end
    endtask

    task automatic run_random(input int count);
        logic [31:0]     r;
        logic [31:0]     s;
        logic [4:0]      ra;
        logic [4:0]      rb;
        logic [4:0]      rc;
        logic [5:0]      fn;
        mips_pkg::word_t iw;
        for (int n = 0; n < count; n++)
        begin
            r  = lcg_next();
            s  = lcg_next();
            // r0..r7 only, so results feed each other often
            ra = {2'b00, s[15:13]};
            rb = {2'b00, s[12:10]};
            rc = {2'b00, s[9:7]};
            case (r[26:24])
                3'd0:    fn = 6'd34;
                3'd1:    fn = 6'd36;
                3'd2:    fn = 6'd37;
                3'd3:    fn = 6'd42;
                default: fn = 6'd32;
            endcase
            case (r[31:29])
                3'd2:    iw = enc_i(6'd8, ra, rb, s[31:16]);
                3'd3:    iw = enc_i(6'd12, ra, rb, s[31:16]);
                3'd4:    iw = enc_i(6'd13, ra, rb, s[31:16]);
                3'd5:    iw = enc_i(6'd8, ra, rb, s[31:16]);
                // mostly illegal, sometimes legal by chance
                3'd7:    iw = {s[31:16], r[23:8]};
                default: iw = enc_r(ra, rb, rc, fn);
            endcase
            issue("random stream", iw);
            if (r[28:27] == 2'b00)
            begin
                idle(1);
            end
        end
    endtask

    // compare outputs against queued entries
    always @(posedge clk)
    begin
        if (arst_n && (result_valid || illegal))
        begin
            if (exp_name.size() == 0)
            begin
                $display("unexpected output with empty queue (result_valid %0b, illegal %0b)",
                         result_valid, illegal);
                $display("tests failed");
                $fatal(1);
            end
            else
            begin
                cur_name  = exp_name.pop_front();
                cur_bad   = exp_bad.pop_front();
                cur_reg   = exp_reg.pop_front();
                cur_data  = exp_data.pop_front();
                cur_count = exp_count.pop_front();
                if ((illegal !== cur_bad) || (result_valid === cur_bad))
                begin
                    $display("%s: wrong kind of output, expected %s", cur_name,
                             cur_bad ? "an illegal pulse" : "a valid result");
                    $display("tests failed");
                    $fatal(1);
                end
                else if (cur_bad)
                begin
                    check_count(cur_name, cur_count, retired_count);
                end
                else
                begin
                    check_reg(cur_name, cur_reg, result_reg);
                    check_word(cur_name, cur_data, result);
                    check_count(cur_name, cur_count, retired_count);
                end
            end
        end
    end

    initial
    begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired with %0d results still outstanding", exp_name.size());
        $display("tests failed");
        $fatal(1);
    end

    initial
    begin
        arst_n      = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        model_count = '0;
        lcg_state   = 32'd8124;
        for (int i = 0; i < `MIPS_NREGS; i++)
        begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_count("count after reset", '0, retired_count);

        // registers read as zero after reset
        issue("reset add", enc_r(5'd3, 5'd1, 5'd2, 6'd32));
        issue("reset or", enc_r(5'd4, 5'd5, 5'd6, 6'd37));

        // every operation
        issue("addi sign extension", enc_i(6'd8, 5'd1, 5'd0, 16'hfffb));
        issue("ori zero extension", enc_i(6'd13, 5'd2, 5'd0, 16'h8001));
        issue("andi zero extension", enc_i(6'd12, 5'd3, 5'd1, 16'hf0f0));
        issue("addi all ones", enc_i(6'd8, 5'd4, 5'd0, 16'hffff));
        issue("add wrap", enc_r(5'd5, 5'd4, 5'd4, 6'd32));
        issue("sub wrap", enc_r(5'd6, 5'd0, 5'd4, 6'd34));
        issue("sub negative", enc_r(5'd7, 5'd2, 5'd1, 6'd34));
        issue("slt signed true", enc_r(5'd8, 5'd4, 5'd2, 6'd42));
        issue("slt signed false", enc_r(5'd9, 5'd2, 5'd4, 6'd42));
        issue("and", enc_r(5'd10, 5'd2, 5'd1, 6'd36));
        issue("or", enc_r(5'd11, 5'd3, 5'd2, 6'd37));
        issue("ori upper clear", enc_i(6'd13, 5'd12, 5'd4, 16'h1234));
        idle(2);

        // distance one uses the bypass, distance two the register file
        issue("dependency addi", enc_i(6'd8, 5'd1, 5'd0, 16'd7));
        issue("dependency bypass", enc_r(5'd2, 5'd1, 5'd1, 6'd32));
        issue("dependency mixed", enc_r(5'd3, 5'd2, 5'd1, 6'd34));
        issue("dependency or", enc_r(5'd4, 5'd3, 5'd2, 6'd37));
        issue("dependency slt", enc_r(5'd5, 5'd4, 5'd3, 6'd42));
        issue("dependency self", enc_i(6'd8, 5'd5, 5'd5, 16'd100));
        issue("dependency and", enc_r(5'd6, 5'd5, 5'd4, 6'd36));
        idle(2);

        // r0 write reported, never stored
        issue("r0 write", enc_i(6'd8, 5'd0, 5'd0, 16'd55));
        issue("r0 read next", enc_r(5'd5, 5'd0, 5'd0, 6'd32));
        issue("r0 read later", enc_r(5'd6, 5'd0, 5'd0, 6'd37));
        issue("r0 with source", enc_r(5'd8, 5'd0, 5'd1, 6'd32));
        idle(2);

        // illegal encodings leave r1 alone
        issue("illegal setup", enc_i(6'd8, 5'd1, 5'd0, 16'd3));
        issue("illegal load", enc_i(6'd35, 5'd1, 5'd0, 16'd99));
        issue("illegal shift", enc_r(5'd1, 5'd0, 5'd0, 6'd0));
        issue("illegal nor", enc_r(5'd1, 5'd1, 5'd1, 6'd39));
        issue("illegal jump", enc_i(6'd2, 5'd1, 5'd1, 16'h0040));
        issue("after illegal", enc_r(5'd2, 5'd1, 5'd0, 6'd32));
        issue("after illegal imm", enc_i(6'd8, 5'd3, 5'd1, 16'd1));
        idle(2);

        run_random(NUM_RANDOM);
        idle(1);

        // drain the last results
        while (exp_name.size() != 0)
        begin
            @(negedge clk);
        end
        check_count("final count", model_count, retired_count);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_consts.svh"

module mips_datapath
(
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  inst_valid,
    input  wire mips_pkg::word_t       inst,
    output logic                       result_valid,
    output mips_pkg::word_t            result,
    output mips_pkg::reg_addr_t        result_reg,
    output logic                       illegal,
    output logic [`MIPS_CNT_W-1:0]     retired_count
);

    // decoder to execute
    logic                d_valid;
    logic                d_illegal;
    logic                d_use_imm;
    mips_pkg::reg_addr_t d_rs;
    mips_pkg::reg_addr_t d_rt;
    mips_pkg::reg_addr_t d_wr_addr;
    mips_pkg::alu_op_e   d_alu_op;
    mips_pkg::word_t     d_imm;

    // execute to result stage
    logic                x_valid;
    logic                x_illegal;
    mips_pkg::reg_addr_t x_wr_addr;
    mips_pkg::word_t     x_result;

    // write-back and bypass path
    logic                wb_valid;
    mips_pkg::reg_addr_t wb_addr;
    mips_pkg::word_t     wb_data;

    inst_decoder u_inst_decoder
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .d_rs       (d_rs),
        .d_rt       (d_rt),
        .d_wr_addr  (d_wr_addr),
        .d_alu_op   (d_alu_op),
        .d_imm      (d_imm),
        .d_valid    (d_valid),
        .d_illegal  (d_illegal),
        .d_use_imm  (d_use_imm)
    );

    exec_unit u_exec_unit
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .d_valid   (d_valid),
        .d_illegal (d_illegal),
        .d_rs      (d_rs),
        .d_rt      (d_rt),
        .d_wr_addr (d_wr_addr),
        .d_alu_op  (d_alu_op),
        .d_use_imm (d_use_imm),
        .d_imm     (d_imm),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .x_valid   (x_valid),
        .x_illegal (x_illegal),
        .x_wr_addr (x_wr_addr),
        .x_result  (x_result)
    );

    result_stage u_result_stage
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .x_valid       (x_valid),
        .x_illegal     (x_illegal),
        .x_wr_addr     (x_wr_addr),
        .x_result      (x_result),
        .result_valid  (result_valid),
        .result        (result),
        .result_reg    (result_reg),
        .illegal       (illegal),
        .retired_count (retired_count),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data)
    );

endmodule

`default_nettype wire

// File: rtl/result_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_consts.svh"

module result_stage
(
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  x_valid,
    input  wire logic                  x_illegal,
    input  wire mips_pkg::reg_addr_t   x_wr_addr,
    input  wire mips_pkg::word_t       x_result,
    output logic                       result_valid,
    output mips_pkg::word_t            result,
    output mips_pkg::reg_addr_t        result_reg,
    output logic                       illegal,
    output logic [`MIPS_CNT_W-1:0]     retired_count,
    output logic                       wb_valid,
    output mips_pkg::reg_addr_t        wb_addr,
    output mips_pkg::word_t            wb_data
);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            result_valid  <= 1'b0;
            illegal       <= 1'b0;
            result        <= '0;
            result_reg    <= '0;
            retired_count <= '0;
        end
        else
        begin
            result_valid <= x_valid;
            // one-cycle pulse per illegal instruction
            illegal      <= x_illegal;
            // payload only follows valid results
            if (x_valid)
            begin
                result        <= x_result;
                result_reg    <= x_wr_addr;
                // wraps on overflow
                retired_count <= retired_count + 1'b1;
            end
        end
    end

    // write-back uses the same registered result
    assign wb_valid = result_valid;
    assign wb_addr  = result_reg;
    assign wb_data  = result;

    // an illegal slot never retires
    assert property (@(posedge clk) disable iff (!arst_n) !(illegal && result_valid));

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit
(
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  d_valid,
    input  wire logic                  d_illegal,
    input  wire mips_pkg::reg_addr_t   d_rs,
    input  wire mips_pkg::reg_addr_t   d_rt,
    input  wire mips_pkg::reg_addr_t   d_wr_addr,
    input  wire mips_pkg::alu_op_e     d_alu_op,
    input  wire logic                  d_use_imm,
    input  wire mips_pkg::word_t       d_imm,
    input  wire logic                  wb_valid,
    input  wire mips_pkg::reg_addr_t   wb_addr,
    input  wire mips_pkg::word_t       wb_data,
    output logic                       x_valid,
    output logic                       x_illegal,
    output mips_pkg::reg_addr_t        x_wr_addr,
    output mips_pkg::word_t            x_result
);

    mips_pkg::word_t rf_data1;
    mips_pkg::word_t rf_data2;
    mips_pkg::word_t src_a;
    mips_pkg::word_t src_b;
    mips_pkg::word_t op_b;
    logic            fwd_a;
    logic            fwd_b;

    // written from the result registers, one cycle behind
    reg_file u_reg_file
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_addr1 (d_rs),
        .rd_addr2 (d_rt),
        .wr_en    (wb_valid),
        .wr_addr  (wb_addr),
        .wr_data  (wb_data),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2)
    );

    // bypass from the previous result when it targets a source
    // r0 never forwards
    assign fwd_a = wb_valid && (wb_addr != '0) && (wb_addr == d_rs);
    assign fwd_b = wb_valid && (wb_addr != '0) && (wb_addr == d_rt);

    assign src_a = fwd_a ? wb_data : rf_data1;
    assign src_b = fwd_b ? wb_data : rf_data2;

    // second operand
    assign op_b = d_use_imm ? d_imm : src_b;

    always_comb
    begin
        case (d_alu_op)
            // add and sub simply wrap
            mips_pkg::ALU_ADD: x_result = src_a + op_b;
            mips_pkg::ALU_SUB: x_result = src_a - op_b;
            mips_pkg::ALU_AND: x_result = src_a & op_b;
            mips_pkg::ALU_OR:  x_result = src_a | op_b;
            // signed compare, 1 or 0
            mips_pkg::ALU_SLT: x_result = mips_pkg::word_t'($signed(src_a) < $signed(op_b));
            default:           x_result = '0;
        endcase
    end

    // control passes straight to the result stage
    assign x_valid   = d_valid;
    assign x_illegal = d_illegal;
    assign x_wr_addr = d_wr_addr;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_consts.svh"

module reg_file
(
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire mips_pkg::reg_addr_t   rd_addr1,
    input  wire mips_pkg::reg_addr_t   rd_addr2,
    input  wire logic                  wr_en,
    input  wire mips_pkg::reg_addr_t   wr_addr,
    input  wire mips_pkg::word_t       wr_data,
    output mips_pkg::word_t            rd_data1,
    output mips_pkg::word_t            rd_data2
);

    // architectural registers
    mips_pkg::word_t regs [`MIPS_NREGS];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `MIPS_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_addr != '0))
        begin
            // r0 stays at zero
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, r0 hardwired
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

    // write address must be known when a write is requested
    assert property (@(posedge clk) disable iff (!arst_n) wr_en |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_consts.svh"

module inst_decoder
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              inst_valid,
    input  wire mips_pkg::word_t   inst,
    output mips_pkg::reg_addr_t    d_rs,
    output mips_pkg::reg_addr_t    d_rt,
    output mips_pkg::reg_addr_t    d_wr_addr,
    output mips_pkg::alu_op_e      d_alu_op,
    output mips_pkg::word_t        d_imm,
    output logic                   d_valid,
    output logic                   d_illegal,
    output logic                   d_use_imm
);

    // instruction fields
    mips_pkg::opcode_e             opcode;
    mips_pkg::funct_e              funct;
    logic [`MIPS_IMM_W-1:0]        imm_field;

    // combinational decode results
    mips_pkg::alu_op_e             alu_op;
    mips_pkg::word_t               ext_imm;
    logic                          legal;
    logic                          use_imm;
    logic                          reg_dst;
    logic                          sign_ext;

    assign opcode    = mips_pkg::opcode_e'(inst[31:26]);
    assign funct     = mips_pkg::funct_e'(inst[5:0]);
    assign imm_field = inst[`MIPS_IMM_W-1:0];

    always_comb
    begin
        // defaults match an r-type add
        alu_op   = mips_pkg::ALU_ADD;
        legal    = 1'b1;
        use_imm  = 1'b0;
        reg_dst  = 1'b0;
        sign_ext = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE:
            begin
                // destination is rd
                reg_dst = 1'b1;
                case (funct)
                    mips_pkg::F_ADD: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUB: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND: alu_op = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:  alu_op = mips_pkg::ALU_OR;
                    mips_pkg::F_SLT: alu_op = mips_pkg::ALU_SLT;
                    default:         legal  = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDI:
            begin
                alu_op   = mips_pkg::ALU_ADD;
                use_imm  = 1'b1;
                sign_ext = 1'b1;
            end
            mips_pkg::OP_ANDI:
            begin
                alu_op  = mips_pkg::ALU_AND;
                use_imm = 1'b1;
            end
            mips_pkg::OP_ORI:
            begin
                alu_op  = mips_pkg::ALU_OR;
                use_imm = 1'b1;
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
    end

    // sign extension for addi only, zero fill for logic ops
    assign ext_imm = sign_ext ?
        {{(`MIPS_XLEN-`MIPS_IMM_W){imm_field[`MIPS_IMM_W-1]}}, imm_field} :
        {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, imm_field};

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            d_valid   <= 1'b0;
            d_illegal <= 1'b0;
            d_use_imm <= 1'b0;
            d_rs      <= '0;
            d_rt      <= '0;
            d_wr_addr <= '0;
            d_alu_op  <= mips_pkg::ALU_ADD;
            d_imm     <= '0;
        end
        else
        begin
            d_valid   <= inst_valid && legal;
            d_illegal <= inst_valid && !legal;
            d_use_imm <= use_imm;
            d_rs      <= inst[25:21];
            d_rt      <= inst[20:16];
            // reg_dst picks rd for r-type, rt otherwise
            d_wr_addr <= reg_dst ? inst[15:11] : inst[20:16];
            d_alu_op  <= alu_op;
            d_imm     <= ext_imm;
        end
    end

    // a strobed instruction word is fully known
    assert property (@(posedge clk) disable iff (!arst_n) inst_valid |-> !$isunknown(inst));

endmodule

`default_nettype wire

// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    `include "mips_consts.svh"

    // one data word
    typedef logic [`MIPS_XLEN-1:0] word_t;

    // register number
    typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13
    } opcode_e;

    // r-type funct field, inst[5:0]
    typedef enum logic [5:0]
    {
        F_ADD = 6'd32,
        F_SUB = 6'd34,
        F_AND = 6'd36,
        F_OR  = 6'd37,
        F_SLT = 6'd42
    } funct_e;

    // internal alu operation
    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

endpackage

`default_nettype wire

// File: include/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// data word width in bits
`define MIPS_XLEN 32

// number of architectural registers
`define MIPS_NREGS 32

// register address width
// must cover MIPS_NREGS entries
`define MIPS_REG_AW 5

// width of the instruction immediate field
`define MIPS_IMM_W 16

// width of the retired instruction counter
`define MIPS_CNT_W 16

`endif
